//--- exec_sequencer.sv
module exec_sequencer
    import rv_isa_pkg::*;
    import rv_ctrl_sig_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         class_valid,
    input  instr_class_t instr_class,
    input  mem_size_t    mem_size,
    input  logic         comparator,  // Branch condition from the datapath
    output logic         pc_en,
    output pc_sel_t      pc_select,
    output logic         alu_src,     // 1 selects the immediate for ALU input b
    output logic         reg_write,
    output wb_sel_t      wb_select,
    output logic         is_byte,
    output logic         is_half,
    output logic         is_word,
    output logic         mem_read,
    output logic         mem_write,
    output logic         exec_done,
    output logic         illegal
);

    typedef enum logic [1:0]
    {
        IDLE,
        STEP1,
        STEP2,
        DONE
    } exec_state_t;

    exec_state_t state;
    exec_state_t state_next;

    logic    pc_en_next;
    pc_sel_t pc_select_next;
    logic    alu_src_next;
    logic    reg_write_next;
    wb_sel_t wb_select_next;
    logic    mem_read_next;
    logic    mem_write_next;
    logic    mem_access;
    logic    exec_done_next;
    logic    illegal_next;

    //////////////////////////////
    // Step decode
    //////////////////////////////

    // Values computed here appear on the outputs one edge later
    always_comb
    begin
        state_next     = state;
        pc_en_next     = 1'b0;
        pc_select_next = PC_PLUS4;
        alu_src_next   = 1'b0;
        reg_write_next = 1'b0;
        wb_select_next = WB_ALU;
        mem_read_next  = 1'b0;
        mem_write_next = 1'b0;
        exec_done_next = 1'b0;
        illegal_next   = 1'b0;

        case (state)
            IDLE:
            begin
                if (class_valid)
                begin
                    state_next = STEP1;

                    // First step of each class
                    case (instr_class)
                        CLS_R:
                            reg_write_next = 1'b1;
                        CLS_I:
                        begin
                            reg_write_next = 1'b1;
                            alu_src_next   = 1'b1;
                        end
                        CLS_LOAD:
                        begin
                            mem_read_next  = 1'b1;
                            alu_src_next   = 1'b1;  // Base plus offset
                            wb_select_next = WB_MEM;
                        end
                        CLS_STORE:
                        begin
                            mem_write_next = 1'b1;
                            alu_src_next   = 1'b1;
                        end
                        CLS_BRANCH:
                        begin
                            // Comparator is stable since the fetch
                            pc_en_next     = comparator;
                            pc_select_next = comparator ? PC_BRANCH : PC_PLUS4;
                        end
                        CLS_JAL, CLS_JALR:
                        begin
                            reg_write_next = 1'b1;
                            pc_en_next     = 1'b1;
                            wb_select_next = WB_LINK;
                            alu_src_next   = (instr_class == CLS_JALR);
                            pc_select_next = (instr_class == CLS_JALR) ? PC_JALR : PC_JAL;
                        end
                        default:
                        begin
                            // No steps, straight to completion
                            state_next     = DONE;
                            exec_done_next = 1'b1;
                            illegal_next   = 1'b1;
                        end
                    endcase
                end
            end

            STEP1:
            begin
                if (instr_class == CLS_LOAD)
                begin
                    state_next     = STEP2;
                    reg_write_next = 1'b1;  // Write the loaded data back
                    alu_src_next   = 1'b1;
                    wb_select_next = WB_MEM;
                end
                else
                begin
                    state_next     = DONE;
                    exec_done_next = 1'b1;
                end
            end

            STEP2:
            begin
                state_next     = DONE;
                exec_done_next = 1'b1;
            end

            DONE:
                state_next = IDLE;

            default:
                state_next = IDLE;
        endcase
    end

    assign mem_access = mem_read_next | mem_write_next;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state     <= IDLE;
            pc_en     <= 1'b0;
            pc_select <= PC_SEL_RST;
            alu_src   <= 1'b0;
            reg_write <= 1'b0;
            wb_select <= WB_SEL_RST;
            is_byte   <= 1'b0;
            is_half   <= 1'b0;
            is_word   <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            exec_done <= 1'b0;
            illegal   <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            pc_en     <= pc_en_next;
            pc_select <= pc_select_next;
            alu_src   <= alu_src_next;
            reg_write <= reg_write_next;
            wb_select <= wb_select_next;
            is_byte   <= mem_access && (mem_size == SIZE_BYTE);  // One-hot size strobes
            is_half   <= mem_access && (mem_size == SIZE_HALF);
            is_word   <= mem_access && (mem_size == SIZE_WORD);
            mem_read  <= mem_read_next;
            mem_write <= mem_write_next;
            exec_done <= exec_done_next;
            illegal   <= illegal_next;
        end
    end

    //////////////////////////////
    // Memory strobe checks
    //////////////////////////////

    size_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({is_byte, is_half, is_word}))
        else $error("more than one size strobe high");

    size_with_access: assert property (@(posedge clk) disable iff (reset)
        (is_byte || is_half || is_word) |-> (mem_read || mem_write))
        else $error("size strobe without a memory access");

    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write high together");

endmodule

//--- instr_classifier.sv
module instr_classifier
    import rv_isa_pkg::*;
    import rv_ctrl_sig_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         decode_start,
    input  opcode_t      opcode,
    input  funct3_t      funct3,
    output logic         class_valid,
    output instr_class_t instr_class,  // Held until the next decode_start
    output mem_size_t    mem_size
);

    instr_class_t class_next;
    mem_size_t    size_next;

    //////////////////////////////
    // Opcode and size decode
    //////////////////////////////

    always_comb
    begin
        class_next = CLS_ILLEGAL;
        size_next  = SIZE_WORD;  // Don't care outside loads and stores

        case (opcode)
            OP_RTYPE:                   class_next = CLS_R;
            OP_ITYPE, OP_LUI, OP_AUIPC: class_next = CLS_I;
            OP_BRANCH:                  class_next = CLS_BRANCH;
            OP_JAL:                     class_next = CLS_JAL;
            OP_JALR:                    class_next = CLS_JALR;

            OP_LOAD:
            begin
                // Signed and unsigned loads share a size
                case (funct3)
                    F3_BYTE, F3_BYTE_U:
                    begin
                        class_next = CLS_LOAD;
                        size_next  = SIZE_BYTE;
                    end
                    F3_HALF, F3_HALF_U:
                    begin
                        class_next = CLS_LOAD;
                        size_next  = SIZE_HALF;
                    end
                    F3_WORD:
                        class_next = CLS_LOAD;
                    default:
                        class_next = CLS_ILLEGAL;
                endcase
            end

            OP_STORE:
            begin
                case (funct3)
                    F3_BYTE:
                    begin
                        class_next = CLS_STORE;
                        size_next  = SIZE_BYTE;
                    end
                    F3_HALF:
                    begin
                        class_next = CLS_STORE;
                        size_next  = SIZE_HALF;
                    end
                    F3_WORD:
                        class_next = CLS_STORE;
                    default:
                        class_next = CLS_ILLEGAL;
                endcase
            end

            default:
                class_next = CLS_ILLEGAL;  // Unknown opcode
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            class_valid <= 1'b0;
        else
            class_valid <= decode_start;
    end

    always_ff @(posedge clk)
    begin
        if (decode_start)
        begin
            instr_class <= class_next;
            mem_size    <= size_next;
        end
    end

    valid_follows_start: assert property (@(posedge clk) disable iff (reset)
        class_valid |-> $past(decode_start))
        else $error("class_valid without decode_start one cycle earlier");

endmodule

//--- instr_sequencer.sv
module instr_sequencer
    import rv_ctrl_sig_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    go,            // Start or continue execution
    input  logic    exec_done,     // Execution phase finished
    output logic    ir_en,         // Load instruction register
    output logic    pc_en,         // Sequential PC update
    output pc_sel_t pc_select,
    output logic    decode_start,  // Kick the classifier
    output logic    instr_done
);

    typedef enum logic [2:0]
    {
        IDLE,
        FETCH,
        PC_STEP,
        DECODE,
        WAIT_EXEC
    } seq_state_t;

    seq_state_t state;

    //////////////////////////////
    // Front-end phase FSM
    //////////////////////////////

    // Strobes are registered so each one lines up with its state
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state        <= IDLE;
            ir_en        <= 1'b0;
            pc_en        <= 1'b0;
            decode_start <= 1'b0;
        end
        else
        begin
            ir_en        <= 1'b0;
            pc_en        <= 1'b0;
            decode_start <= 1'b0;

            case (state)
                IDLE:
                begin
                    if (go)
                    begin
                        state <= FETCH;
                        ir_en <= 1'b1;
                    end
                end

                FETCH:
                begin
                    state <= PC_STEP;
                    pc_en <= 1'b1;  // PC+4 right after the fetch
                end

                PC_STEP:
                begin
                    state        <= DECODE;
                    decode_start <= 1'b1;
                end

                DECODE:
                    state <= WAIT_EXEC;

                WAIT_EXEC:
                begin
                    // Back-to-back issue when go is still high
                    if (exec_done)
                    begin
                        if (go)
                        begin
                            state <= FETCH;
                            ir_en <= 1'b1;
                        end
                        else
                            state <= IDLE;
                    end
                end

                default:
                    state <= IDLE;
            endcase
        end
    end

    // Completion lines up with the execution side's done pulse
    assign instr_done = (state == WAIT_EXEC) && exec_done;

    // The front end only ever takes the sequential step
    assign pc_select = PC_PLUS4;

    // Fetch and PC step are separate phases of the same instruction
    fetch_pc_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ir_en && pc_en))
        else $error("ir_en and pc_en high in the same cycle");

endmodule

//--- rv_ctrl.f
rv_isa_pkg.sv
rv_ctrl_sig_pkg.sv
instr_sequencer.sv
instr_classifier.sv
exec_sequencer.sv
rv_ctrl_top.sv
rv_ctrl_checker.sv
rv_ctrl_tb.sv

//--- rv_ctrl_checker.sv
module rv_ctrl_checker
    import rv_isa_pkg::*;
    import rv_ctrl_sig_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input logic    go,
    input opcode_t opcode,
    input funct3_t funct3,
    input logic    comparator,
    input logic    ir_en,
    input logic    pc_en,
    input pc_sel_t pc_select,
    input logic    alu_src,
    input logic    reg_write,
    input wb_sel_t wb_select,
    input logic    is_byte,
    input logic    is_half,
    input logic    is_word,
    input logic    mem_read,
    input logic    mem_write,
    input logic    instr_done,
    input logic    illegal
);
    timeunit 1ns;
    timeprecision 100ps;

    int mismatch_errors = 0;
    int other_errors    = 0;

    logic         active;     // Between ir_en and instr_done
    logic         ir_en_due;  // Fetch expected in this cycle
    int           cycle_no;   // 2 in the PC step cycle
    instr_class_t exp_cls;
    int           exp_k;
    int           step;
    logic         in_step;
    logic         exp_pc_en;
    pc_sel_t      exp_pc_select;
    logic         exp_alu_src;
    logic         exp_reg_write;
    wb_sel_t      exp_wb_select;
    logic         exp_mem_read;
    logic         exp_mem_write;
    logic [2:0]   exp_size;   // {is_byte, is_half, is_word}
    logic         exp_done;
    logic         exp_illegal;
    logic         any_strobe;

    task automatic report_mismatch(input string msg);
        mismatch_errors++;
        $display("mismatch at %0t ns: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    //////////////////////////////
    // Reference rules
    //////////////////////////////

    function automatic instr_class_t class_of(opcode_t op, funct3_t f3);
        case (op)
            OP_RTYPE:                   return CLS_R;
            OP_ITYPE, OP_LUI, OP_AUIPC: return CLS_I;
            OP_BRANCH:                  return CLS_BRANCH;
            OP_JAL:                     return CLS_JAL;
            OP_JALR:                    return CLS_JALR;
            OP_LOAD:
                return (f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) ?
                    CLS_LOAD : CLS_ILLEGAL;
            OP_STORE:
                return (f3 inside {3'b000, 3'b001, 3'b010}) ? CLS_STORE : CLS_ILLEGAL;
            default:                    return CLS_ILLEGAL;
        endcase
    endfunction

    // Low two bits of funct3 give the width, bit 2 only the sign
    function automatic logic [2:0] size_strobes(funct3_t f3);
        case (f3[1:0])
            2'b00:   return 3'b100;
            2'b01:   return 3'b010;
            default: return 3'b001;
        endcase
    endfunction

    always_comb
    begin
        exp_cls       = class_of(opcode, funct3);
        exp_k         = (exp_cls == CLS_LOAD) ? 2 : (exp_cls == CLS_ILLEGAL) ? 0 : 1;
        step          = cycle_no - 4;  // Execution step 1 falls in cycle 5
        in_step       = active && (step >= 1) && (step <= exp_k);
        exp_pc_en     = active && (cycle_no == 2);
        exp_pc_select = PC_PLUS4;
        exp_alu_src   = 1'b0;
        exp_reg_write = 1'b0;
        exp_wb_select = WB_ALU;
        exp_mem_read  = 1'b0;
        exp_mem_write = 1'b0;
        exp_done      = active && (cycle_no == 5 + exp_k);
        exp_illegal   = exp_done && (exp_cls == CLS_ILLEGAL);

        if (in_step)
        begin
            case (exp_cls)
                CLS_R:
                    exp_reg_write = 1'b1;
                CLS_I:
                begin
                    exp_reg_write = 1'b1;
                    exp_alu_src   = 1'b1;
                end
                CLS_LOAD:
                begin
                    exp_mem_read  = (step == 1);
                    exp_reg_write = (step == 2);
                    exp_alu_src   = 1'b1;
                    exp_wb_select = WB_MEM;
                end
                CLS_STORE:
                begin
                    exp_mem_write = 1'b1;
                    exp_alu_src   = 1'b1;
                end
                CLS_BRANCH:
                begin
                    exp_pc_en     = comparator;  // Not taken gives an empty cycle
                    exp_pc_select = PC_BRANCH;
                end
                default:
                begin
                    // JAL and JALR
                    exp_reg_write = 1'b1;
                    exp_pc_en     = 1'b1;
                    exp_wb_select = WB_LINK;
                    exp_alu_src   = (exp_cls == CLS_JALR);
                    exp_pc_select = (exp_cls == CLS_JALR) ? PC_JALR : PC_JAL;
                end
            endcase
        end

        exp_size = (exp_mem_read || exp_mem_write) ? size_strobes(funct3) : 3'b000;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            active    <= 1'b0;
            cycle_no  <= 0;
            ir_en_due <= 1'b0;
        end
        else
        begin
            // Fetch follows go seen while idle or in the completion cycle
            ir_en_due <= go && ((!active && !ir_en) || instr_done);
            if (ir_en)
            begin
                active   <= 1'b1;
                cycle_no <= 2;
            end
            else if (instr_done)
                active <= 1'b0;
            else if (active)
                cycle_no <= cycle_no + 1;
        end
    end

    assign any_strobe = ir_en | pc_en | alu_src | reg_write | is_byte | is_half | is_word |
                        mem_read | mem_write | instr_done | illegal;

    //////////////////////////////
    // Output checks
    //////////////////////////////

    reset_values: assert property (@(posedge clk) (reset && $past(reset)) |->
        (!any_strobe && pc_select == PC_PLUS4 && wb_select == WB_ALU))
        else report_mismatch("outputs not cleared during reset");

    ir_en_check: assert property (@(posedge clk) disable iff (reset)
        ir_en == ir_en_due)
        else report_mismatch("ir_en does not follow go");

    pc_en_check: assert property (@(posedge clk) disable iff (reset)
        pc_en == exp_pc_en)
        else report_mismatch("pc_en differs from the expected strobe");

    pc_select_check: assert property (@(posedge clk) disable iff (reset)
        pc_en |-> pc_select == exp_pc_select)
        else report_mismatch("pc_select wrong while pc_en is high");

    alu_src_check: assert property (@(posedge clk) disable iff (reset)
        alu_src == exp_alu_src)
        else report_mismatch("alu_src differs from the class rule");

    reg_write_check: assert property (@(posedge clk) disable iff (reset)
        reg_write == exp_reg_write)
        else report_mismatch("reg_write differs from the class rule");

    wb_select_check: assert property (@(posedge clk) disable iff (reset)
        wb_select == exp_wb_select)
        else report_mismatch("wb_select differs from the class rule");

    size_check: assert property (@(posedge clk) disable iff (reset)
        {is_byte, is_half, is_word} == exp_size)
        else report_mismatch("size strobes do not match funct3");

    mem_read_check: assert property (@(posedge clk) disable iff (reset)
        mem_read == exp_mem_read)
        else report_mismatch("mem_read differs from the class rule");

    mem_write_check: assert property (@(posedge clk) disable iff (reset)
        mem_write == exp_mem_write)
        else report_mismatch("mem_write differs from the class rule");

    done_check: assert property (@(posedge clk) disable iff (reset)
        instr_done == exp_done)
        else report_mismatch("instr_done not at 5+k cycles");

    illegal_check: assert property (@(posedge clk) disable iff (reset)
        illegal == exp_illegal)
        else report_mismatch("illegal differs from the decode rule");

    done_has_fetch: assert property (@(posedge clk) disable iff (reset)
        instr_done |-> active)
        else report_failure("instr_done arrived with no instruction in flight");

    done_in_time: assert property (@(posedge clk) disable iff (reset)
        active |-> cycle_no <= 12)
        else report_failure("instr_done did not arrive within 12 cycles of ir_en");

endmodule

//--- rv_ctrl_sig_pkg.sv
package rv_ctrl_sig_pkg;

    //////////////////////////////
    // Next-PC select
    //////////////////////////////

    typedef logic [1:0] pc_sel_t;

    localparam pc_sel_t PC_PLUS4  = 2'd0;  // Sequential step
    localparam pc_sel_t PC_BRANCH = 2'd1;  // PC plus B-immediate
    localparam pc_sel_t PC_JAL    = 2'd2;  // PC plus J-immediate
    localparam pc_sel_t PC_JALR   = 2'd3;  // rs1 plus I-immediate

    //////////////////////////////
    // Register write-back select
    //////////////////////////////

    typedef logic [1:0] wb_sel_t;

    localparam wb_sel_t WB_ALU  = 2'd0;
    localparam wb_sel_t WB_MEM  = 2'd1;
    localparam wb_sel_t WB_LINK = 2'd2;  // Return address PC+4

    // Memory access size
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    // Select values held while reset is asserted
    localparam pc_sel_t PC_SEL_RST = PC_PLUS4;
    localparam wb_sel_t WB_SEL_RST = WB_ALU;

endpackage

//--- rv_ctrl_tb.sv
module rv_ctrl_tb
    import rv_isa_pkg::*;
    import rv_ctrl_sig_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTR        = 300;
    localparam int MAX_INSTR_CYCLES = 12;
    localparam int CLK_PERIOD       = 4;  // ns
    localparam int WATCHDOG_NS      = NUM_INSTR * MAX_INSTR_CYCLES * CLK_PERIOD + 200;

    logic    clk;
    logic    reset;
    logic    go;
    opcode_t opcode;
    funct3_t funct3;
    logic    comparator;
    logic    ir_en;
    logic    pc_en;
    pc_sel_t pc_select;
    logic    alu_src;
    logic    reg_write;
    wb_sel_t wb_select;
    logic    is_byte;
    logic    is_half;
    logic    is_word;
    logic    mem_read;
    logic    mem_write;
    logic    instr_done;
    logic    illegal;

    int wait_errors = 0;
    int instr_count = 0;

    rv_ctrl_top u_dut (.*);

    rv_ctrl_checker u_checker (.*);

    initial
        clk = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Weighted over all classes, with a share of arbitrary opcodes
    function automatic opcode_t pick_opcode();
        int unsigned r;
        r = $urandom_range(0, 17);
        case (r)
            0, 1, 2:    return OP_RTYPE;
            3, 4:       return OP_ITYPE;
            5:          return OP_LUI;
            6:          return OP_AUIPC;
            7, 8, 9:    return OP_LOAD;
            10, 11:     return OP_STORE;
            12, 13, 14: return OP_BRANCH;
            15:         return OP_JAL;
            16:         return OP_JALR;
            default:    return opcode_t'($urandom);
        endcase
    endfunction

    task automatic drive_instruction();
        opcode     <= pick_opcode();
        funct3     <= funct3_t'($urandom);  // Covers bad load and store sizes
        comparator <= 1'($urandom_range(0, 1));
        go         <= 1'b1;
    endtask

    task automatic wait_for_done();
        int n;
        n = 0;
        @(negedge clk);
        while (!instr_done && n < MAX_INSTR_CYCLES)
        begin
            @(negedge clk);
            n++;
        end
        if (!instr_done)
        begin
            wait_errors++;
            $display("instr_done did not arrive within %0d cycles at %0t ns",
                     MAX_INSTR_CYCLES, $time);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        logic pause;

        void'($urandom(20551));
        reset      = 1'b1;
        go         = 1'b0;
        opcode     = OP_RTYPE;
        funct3     = F3_BYTE;
        comparator = 1'b0;

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        drive_instruction();

        for (int i = 0; i < NUM_INSTR; i++)
        begin
            pause = ($urandom_range(0, 9) == 0) || (i == NUM_INSTR - 1);
            @(posedge clk);
            if (pause)
                go <= 1'b0;  // Ignored until the instruction completes
            wait_for_done();
            @(posedge clk);  // Closes the instr_done cycle
            instr_count++;
            if (pause)
                repeat ($urandom_range(1, 4)) @(posedge clk);
            if (i < NUM_INSTR - 1)
                drive_instruction();
        end

        repeat (4) @(posedge clk);
        $display("Errors: mismatch %0d, other %0d, wait %0d, after %0d instructions",
                 u_checker.mismatch_errors, u_checker.other_errors, wait_errors, instr_count);
        if (u_checker.mismatch_errors + u_checker.other_errors + wait_errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- rv_ctrl_top.sv
module rv_ctrl_top
    import rv_isa_pkg::*;
    import rv_ctrl_sig_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    go,
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  logic    comparator,
    output logic    ir_en,
    output logic    pc_en,
    output pc_sel_t pc_select,
    output logic    alu_src,
    output logic    reg_write,
    output wb_sel_t wb_select,
    output logic    is_byte,
    output logic    is_half,
    output logic    is_word,
    output logic    mem_read,
    output logic    mem_write,
    output logic    instr_done,
    output logic    illegal
);

    logic         decode_start;
    logic         class_valid;
    instr_class_t instr_class;
    mem_size_t    mem_size;
    logic         exec_done;

    logic    seq_pc_en;      // PC step phase
    pc_sel_t seq_pc_select;
    logic    exec_pc_en;     // Branch and jump steps
    pc_sel_t exec_pc_select;

    instr_sequencer u_instr_sequencer (
        .clk          (clk),
        .reset        (reset),
        .go           (go),
        .exec_done    (exec_done),
        .ir_en        (ir_en),
        .pc_en        (seq_pc_en),
        .pc_select    (seq_pc_select),
        .decode_start (decode_start),
        .instr_done   (instr_done)
    );

    instr_classifier u_instr_classifier (
        .clk          (clk),
        .reset        (reset),
        .decode_start (decode_start),
        .opcode       (opcode),
        .funct3       (funct3),
        .class_valid  (class_valid),
        .instr_class  (instr_class),
        .mem_size     (mem_size)
    );

    exec_sequencer u_exec_sequencer (
        .clk         (clk),
        .reset       (reset),
        .class_valid (class_valid),
        .instr_class (instr_class),
        .mem_size    (mem_size),
        .comparator  (comparator),
        .pc_en       (exec_pc_en),
        .pc_select   (exec_pc_select),
        .alu_src     (alu_src),
        .reg_write   (reg_write),
        .wb_select   (wb_select),
        .is_byte     (is_byte),
        .is_half     (is_half),
        .is_word     (is_word),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .exec_done   (exec_done),
        .illegal     (illegal)
    );

    // The two PC owners are active in different phases
    assign pc_en     = seq_pc_en | exec_pc_en;
    assign pc_select = exec_pc_en ? exec_pc_select : seq_pc_select;

endmodule

//--- rv_isa_pkg.sv
package rv_isa_pkg;

    //////////////////////////////
    // Major opcode field, bits 6:0
    //////////////////////////////

    typedef logic [6:0] opcode_t;

    localparam opcode_t OP_RTYPE  = 7'b0110011;  // ADD, SUB, AND, ...
    localparam opcode_t OP_ITYPE  = 7'b0010011;  // ADDI, ANDI, SLLI, ...
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    //////////////////////////////
    // Minor opcode field, bits 14:12
    //////////////////////////////

    typedef logic [2:0] funct3_t;

    // Size codes shared by loads and stores
    localparam funct3_t F3_BYTE   = 3'b000;
    localparam funct3_t F3_HALF   = 3'b001;
    localparam funct3_t F3_WORD   = 3'b010;
    localparam funct3_t F3_BYTE_U = 3'b100;  // Loads only
    localparam funct3_t F3_HALF_U = 3'b101;  // Loads only

    //////////////////////////////
    // Instruction classes
    //////////////////////////////

    // LUI and AUIPC fold into CLS_I
    typedef enum logic [2:0]
    {
        CLS_R,
        CLS_I,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_ILLEGAL
    } instr_class_t;

endpackage
